//--- hw/tia_settings.svh
// single clock domain on CCLK, NTSC line timing only; objects, motion, collisions and audio absent
`ifndef TIA_SETTINGS_SVH
`define TIA_SETTINGS_SVH

// line timing, in colour clocks
`define TIA_LINE_CLOCKS 228   // counter runs 0..227 then wraps
`define TIA_HSYNC_START 20    // first count with hsync high
`define TIA_HSYNC_END 36      // first count with hsync low again
`define TIA_HBLANK_END 68     // first visible count, pixel 0

// playfield geometry
`define TIA_PF_BITS 20        // bits per half line, 4 clocks each

// processor bus
`define TIA_ADDR_W 6          // a[5:0]
`define TIA_DATA_W 8          // d_in / d_out

// chip select
// only cs[1:0] is decoded, cs[3:2] are don't care
`define TIA_CS_SELECT 2'b01

`endif

//--- hw/tia_pkg.sv
// write and read address maps only; addresses not listed here are ignored on write and read as zero
`include "tia_settings.svh"

package tia_pkg;

  // write addresses, a[5:0] with r_w low
  typedef enum logic [`TIA_ADDR_W-1:0] {
    VSYNC  = 6'h00,  // bit 1 sets vertical sync
    VBLANK = 6'h01,  // bit 1 blank, bit 6 latch mode, bit 7 dump
    WSYNC  = 6'h02,  // strobe, halt cpu until next line
    RSYNC  = 6'h03,  // strobe, restart line counter
    COLUP0 = 6'h06,  // score colour, left half
    COLUP1 = 6'h07,  // score colour, right half
    COLUPF = 6'h08,  // playfield colour
    COLUBK = 6'h09,  // background colour
    CTRLPF = 6'h0A,  // bit 0 reflect, bit 1 score
    PF0    = 6'h0D,  // bits 7:4 only
    PF1    = 6'h0E,
    PF2    = 6'h0F
  } tia_waddr_e;

  // read addresses, a[5:0] with r_w high
  // result always in d_out bit 7
  typedef enum logic [`TIA_ADDR_W-1:0] {
    INPT0 = 6'h08,   // dumped inputs
    INPT1 = 6'h09,
    INPT2 = 6'h0A,
    INPT3 = 6'h0B,
    INPT4 = 6'h0C,   // latched inputs
    INPT5 = 6'h0D
  } tia_raddr_e;

endpackage

//--- hw/tia_regs_if.sv
// strobes here are combinational from the bus cycle and last exactly the cycle of the access
`timescale 1ns/1ps
`include "tia_settings.svh"

interface tia_regs_if;

  // register state, written by decode
  logic                    vsync;     // VSYNC bit 1
  logic [`TIA_DATA_W-1:0]  vblank;    // whole byte, bits 1, 6, 7 used
  logic [`TIA_DATA_W-1:0]  colup0;
  logic [`TIA_DATA_W-1:0]  colup1;
  logic [`TIA_DATA_W-1:0]  colupf;
  logic [`TIA_DATA_W-1:0]  colubk;
  logic                    pf_ref;    // ctrlpf bit 0
  logic                    pf_score;  // ctrlpf bit 1
  logic [`TIA_PF_BITS-1:0] pf;        // pf[k] is column k of the left half

  // single cycle pulses
  logic                    wsync_stb;
  logic                    rsync_stb;
  logic                    vblank_stb;  // VBLANK write with bit 6 set
  logic                    rd_stb;      // any selected read
  tia_pkg::tia_raddr_e     raddr;       // valid with rd_stb

  modport decode (
    output vsync, vblank, colup0, colup1, colupf, colubk,
    output pf_ref, pf_score, pf,
    output wsync_stb, rsync_stb, vblank_stb, rd_stb, raddr
  );

  // vsync / vblank levels listed for the timer, not decoded there yet
  modport beam (input wsync_stb, rsync_stb, vsync, vblank);

  modport video (input colup0, colup1, colupf, colubk, pf_ref, pf_score, pf);

  modport inputs (input vblank, vblank_stb, rd_stb, raddr);

endinterface

//--- hw/tia_reg_decode.sv
// r_w low is a write as on the 6507; only cs[1:0] takes part in chip select
`timescale 1ns/1ps
`include "tia_settings.svh"

module tia_reg_decode (
  input  logic                   CCLK,
  input  logic                   rst_n,
  input  logic                   r_w,    // 1 read, 0 write
  input  logic [3:0]             cs,
  input  logic [`TIA_ADDR_W-1:0] a,
  input  logic [`TIA_DATA_W-1:0] d_in,
  tia_regs_if.decode             regs
);

  logic                sel;    // chip selected this cycle
  logic                wr;     // selected write
  logic                rd;     // selected read
  tia_pkg::tia_waddr_e waddr;

  // msb <-> lsb swap, PF1 is shown msb first
  function automatic logic [`TIA_DATA_W-1:0] bit_rev(input logic [`TIA_DATA_W-1:0] v);
    logic [`TIA_DATA_W-1:0] r;
    for (int k = 0; k < `TIA_DATA_W; k++) begin
      r[k] = v[`TIA_DATA_W-1-k];
    end
    return r;
  endfunction

  // bus qualification
  assign sel   = (cs[1:0] == `TIA_CS_SELECT);
  assign wr    = sel && !r_w;
  assign rd    = sel && r_w;
  assign waddr = tia_pkg::tia_waddr_e'(a);  // unknown codes fall to default

  // strobes, same cycle as the access
  assign regs.wsync_stb  = wr && (waddr == tia_pkg::WSYNC);
  assign regs.rsync_stb  = wr && (waddr == tia_pkg::RSYNC);
  assign regs.vblank_stb = wr && (waddr == tia_pkg::VBLANK) && d_in[6];  // arms latches
  assign regs.rd_stb     = rd;
  assign regs.raddr      = tia_pkg::tia_raddr_e'(a);

  // register writes, visible one cycle later
  always_ff @(posedge CCLK) begin
    if (!rst_n) begin
      regs.vsync    <= 1'b0;
      regs.vblank   <= '0;
      regs.colup0   <= '0;
      regs.colup1   <= '0;
      regs.colupf   <= '0;
      regs.colubk   <= '0;
      regs.pf_ref   <= 1'b0;
      regs.pf_score <= 1'b0;
      regs.pf       <= '0;
    end else if (wr) begin
      case (waddr)
        tia_pkg::VSYNC: begin
          regs.vsync <= d_in[1];
        end
        tia_pkg::VBLANK: begin
          regs.vblank <= d_in;  // keep whole byte, users pick bits
        end
        tia_pkg::COLUP0: begin
          regs.colup0 <= d_in;
        end
        tia_pkg::COLUP1: begin
          regs.colup1 <= d_in;
        end
        tia_pkg::COLUPF: begin
          regs.colupf <= d_in;
        end
        tia_pkg::COLUBK: begin
          regs.colubk <= d_in;
        end
        tia_pkg::CTRLPF: begin
          regs.pf_ref   <= d_in[0];
          regs.pf_score <= d_in[1];  // ball size / priority bits dropped
        end
        tia_pkg::PF0: begin
          regs.pf[3:0] <= d_in[7:4];  // bit 4 is leftmost column
        end
        tia_pkg::PF1: begin
          regs.pf[11:4] <= bit_rev(d_in);  // bit 7 leftmost
        end
        tia_pkg::PF2: begin
          regs.pf[19:12] <= d_in;  // bit 0 leftmost
        end
        default: begin
          // WSYNC / RSYNC are strobes only, rest unmapped
        end
      endcase
    end
  end

endmodule

//--- hw/tia_beam_timer.sv
// rdy is meant for the 6507 RDY pin and is released one cycle after hblank rises
`timescale 1ns/1ps
`include "tia_settings.svh"

module tia_beam_timer (
  input  logic       CCLK,
  input  logic       rst_n,
  tia_regs_if.beam   regs,
  output logic [7:0] hcount,
  output logic       hsync,
  output logic       hblank,
  output logic       rdy
);

  localparam logic [7:0] LAST_COUNT = 8'(`TIA_LINE_CLOCKS - 1);

  logic wsync_halt;  // cpu held while set

  // line counter 0..227
  always_ff @(posedge CCLK) begin
    if (!rst_n) begin
      hcount <= '0;
    end else if (regs.rsync_stb) begin
      hcount <= '0;  // restart line, chip test use
    end else if (hcount == LAST_COUNT) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 8'd1;
    end
  end

  // WSYNC halt
  // a write on the wrap cycle still waits a full line
  always_ff @(posedge CCLK) begin
    if (!rst_n) begin
      wsync_halt <= 1'b0;
    end else if (regs.wsync_stb) begin
      wsync_halt <= 1'b1;
    end else if (hcount == 8'd0) begin
      wsync_halt <= 1'b0;  // start of hblank
    end
  end

  assign rdy = !wsync_halt;

  // horizontal decode straight off the counter
  assign hsync  = (hcount >= 8'(`TIA_HSYNC_START)) && (hcount < 8'(`TIA_HSYNC_END));
  assign hblank = (hcount < 8'(`TIA_HBLANK_END));  // counts 0..67

endmodule

//--- hw/tia_playfield_video.sv
// playfield and background only; 160 visible pixels per line, 4 pixels per playfield column
`timescale 1ns/1ps
`include "tia_settings.svh"

module tia_playfield_video (
  input  logic [7:0] hcount,
  input  logic       hblank,
  tia_regs_if.video  regs,
  output logic [2:0] lum,
  output logic [3:0] col
);

  localparam logic [5:0] HALF_COLS = 6'(`TIA_PF_BITS);
  localparam logic [5:0] LAST_COL  = 6'(2 * `TIA_PF_BITS - 1);  // 39

  logic [7:0]             pixel;      // visible pixel, wraps in hblank
  logic [5:0]             column;     // 0..39 when visible
  logic                   left_half;
  logic [5:0]             pf_idx;     // bit of pf for this column
  logic                   pf_bit;
  logic [`TIA_DATA_W-1:0] colour;     // chosen colour-lum byte

  assign pixel     = hcount - 8'(`TIA_HBLANK_END);
  assign column    = pixel[7:2];
  assign left_half = (column < HALF_COLS);

  // right half repeats or mirrors the left
  always_comb begin
    if (left_half) begin
      pf_idx = column;
    end else if (regs.pf_ref) begin
      pf_idx = LAST_COL - column;  // true mirror, 39 - col
    end else begin
      pf_idx = column - HALF_COLS;
    end
  end

  // out of range only during hblank, where output is zero anyway
  assign pf_bit = (pf_idx < HALF_COLS) ? regs.pf[pf_idx[4:0]] : 1'b0;

  // playfield over background
  always_comb begin
    if (pf_bit) begin
      if (regs.pf_score) begin
        colour = left_half ? regs.colup0 : regs.colup1;  // score mode
      end else begin
        colour = regs.colupf;
      end
    end else begin
      colour = regs.colubk;
    end
  end

  // bit 0 of the colour byte is unused
  assign lum = hblank ? 3'd0 : colour[3:1];
  assign col = hblank ? 4'd0 : colour[7:4];

endmodule

//--- hw/tia_input_ports.sv
// pot ports are plain digital inputs; dump grounds them, no paddle charge timing is modelled
`timescale 1ns/1ps
`include "tia_settings.svh"

module tia_input_ports (
  input  logic                   CCLK,
  input  logic                   rst_n,
  input  logic [5:0]             i,
  tia_regs_if.inputs             regs,
  output logic [`TIA_DATA_W-1:0] d_out
);

  logic [3:0] inpt_dump;   // INPT0..3 as read
  logic [1:0] latch_q;     // INPT4..5 latches
  logic [1:0] inpt_latch;  // INPT4..5 as read
  logic       read_bit;    // selected input

  // dump to ground with vblank bit 7
  assign inpt_dump = regs.vblank[7] ? 4'b0000 : i[3:0];

  // latches
  // forced high by a VBLANK write with bit 6, then sticky low
  always_ff @(posedge CCLK) begin
    if (!rst_n) begin
      latch_q <= 2'b00;
    end else if (regs.vblank_stb) begin
      latch_q <= 2'b11;
    end else if (regs.vblank[6]) begin
      latch_q <= latch_q & i[5:4];  // low input clears for good
    end
  end

  assign inpt_latch = regs.vblank[6] ? latch_q : i[5:4];

  // read mux
  always_comb begin
    case (regs.raddr)
      tia_pkg::INPT0: read_bit = inpt_dump[0];
      tia_pkg::INPT1: read_bit = inpt_dump[1];
      tia_pkg::INPT2: read_bit = inpt_dump[2];
      tia_pkg::INPT3: read_bit = inpt_dump[3];
      tia_pkg::INPT4: read_bit = inpt_latch[0];
      tia_pkg::INPT5: read_bit = inpt_latch[1];
      default:        read_bit = 1'b0;  // unmapped reads as zero
    endcase
  end

  // data out, one cycle after the read, held otherwise
  always_ff @(posedge CCLK) begin
    if (!rst_n) begin
      d_out <= '0;
    end else if (regs.rd_stb) begin
      d_out <= {read_bit, (`TIA_DATA_W-1)'(0)};  // bit 7 only
    end
  end

endmodule

//--- hw/tia_top.sv
// cut-down TIA: playfield, sync and input ports only; single CCLK domain, r_w low writes
`timescale 1ns/1ps
`include "tia_settings.svh"

module tia_top (
  input  logic                   CCLK,
  input  logic                   rst_n,
  input  logic                   r_w,
  input  logic [3:0]             cs,
  input  logic [`TIA_ADDR_W-1:0] a,
  input  logic [`TIA_DATA_W-1:0] d_in,
  input  logic [5:0]             i,      // INPT0..5
  output logic                   rdy,    // to 6507 RDY
  output logic                   hsync,
  output logic                   hblank,
  output logic                   vsync,
  output logic                   vblank,
  output logic [2:0]             lum,
  output logic [3:0]             col,
  output logic [`TIA_DATA_W-1:0] d_out
);

  logic [7:0] hcount;  // beam position, timer to video

  tia_regs_if regs ();

  tia_reg_decode u_decode (
    .CCLK  (CCLK),
    .rst_n (rst_n),
    .r_w   (r_w),
    .cs    (cs),
    .a     (a),
    .d_in  (d_in),
    .regs  (regs.decode)
  );

  tia_beam_timer u_beam (
    .CCLK   (CCLK),
    .rst_n  (rst_n),
    .regs   (regs.beam),
    .hcount (hcount),
    .hsync  (hsync),
    .hblank (hblank),
    .rdy    (rdy)
  );

  tia_playfield_video u_video (
    .hcount (hcount),
    .hblank (hblank),
    .regs   (regs.video),
    .lum    (lum),
    .col    (col)
  );

  tia_input_ports u_inputs (
    .CCLK  (CCLK),
    .rst_n (rst_n),
    .i     (i),
    .regs  (regs.inputs),
    .d_out (d_out)
  );

  assign vsync  = regs.vsync;
  assign vblank = regs.vblank[1];  // blank level only

endmodule

//--- test/tb_clock.sv
// free-running clock from time zero; rst_n is released on a rising edge after RESET_CYCLES edges
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic CCLK,
  output logic rst_n
);

  initial begin
    CCLK = 1'b0;
    forever #(PERIOD_NS / 2) CCLK = ~CCLK;  // 50% duty
  end

  // sync reset, low over the first RESET_CYCLES edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CCLK);
    rst_n <= 1'b1;  // released on an edge like all stimulus
  end

endmodule

//--- test/tb_tia_checks.svh
// included inside tb_tia; uses its bus signals, CCLK and lfsr_state, one idle cycle after each access
`ifndef TB_TIA_CHECKS_SVH
`define TB_TIA_CHECKS_SVH

// one bus access, then chip deselected again
task automatic bus_cycle(input logic [3:0] sel, input logic rw,
                         input logic [5:0] addr, input logic [7:0] data);
  @(posedge CCLK);
  cs   <= sel;
  r_w  <= rw;
  a    <= addr;
  d_in <= data;
  @(posedge CCLK);
  cs  <= 4'b0000;  // idle
  r_w <= 1'b1;
endtask

task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
  bus_cycle(CS_ON, 1'b0, addr, data);  // r_w low writes
endtask

task automatic read_reg(input logic [5:0] addr);
  bus_cycle(CS_ON, 1'b1, addr, 8'h00);
endtask

// waits, all bounded by the cycle limit
task automatic wait_line_start();
  while (hblank) @(posedge CCLK);
  while (!hblank) @(posedge CCLK);  // hblank rise
endtask

task automatic wait_visible();
  while (hblank) @(posedge CCLK);
endtask

task automatic wait_hsync();
  while (!hsync) @(posedge CCLK);
endtask

task automatic wait_ready();
  @(posedge CCLK);  // halt shows one edge after the write
  while (!rdy) @(posedge CCLK);
endtask

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_byte(output logic [7:0] v);
  for (int k = 0; k < 8; k++) begin
    lfsr_state = lfsr_next(lfsr_state);  // one step per bit
    v[k] = lfsr_state[0];
  end
endtask

task automatic write_random(input logic [5:0] addr);
  logic [7:0] v;
  rand_byte(v);
  write_reg(addr, v);
endtask

// left-half column idx 0..19 in screen order
function automatic logic pf_left_bit(input logic [7:0] pf0, pf1, pf2, input int idx);
  if (idx < 4) return pf0[4 + idx];    // PF0 bits 4..7
  if (idx < 12) return pf1[11 - idx];  // PF1 bits 7..0
  return pf2[idx - 12];                // PF2 bits 0..7
endfunction

// expected colour byte for a line position, zero in hblank
function automatic logic [7:0] expect_colour(input logic [7:0] count, pf0, pf1, pf2,
                                            input logic [7:0] ctrl, c0, c1, cpf, cbk);
  int c;    // column 0..39
  int idx;  // left-half column shown there
  if (count < `TIA_HBLANK_END) return 8'h00;
  c = (int'(count) - `TIA_HBLANK_END) / 4;
  if (c < `TIA_PF_BITS) idx = c;
  else if (ctrl[0]) idx = 2 * `TIA_PF_BITS - 1 - c;  // mirror
  else idx = c - `TIA_PF_BITS;                         // repeat
  if (!pf_left_bit(pf0, pf1, pf2, idx)) return cbk;
  if (!ctrl[1]) return cpf;
  return (c < `TIA_PF_BITS) ? c0 : c1;  // score colours by half
endfunction

`endif

//--- test/tb_tia.sv
// checks run as concurrent assertions against a cycle model; needs a simulator with SVA support
`timescale 1ns/1ps
`include "tia_settings.svh"

module tb_tia;

  localparam int WORK_LINES     = 40;  // generous length of all tests, in lines
  localparam int TIMEOUT_CYCLES = WORK_LINES * `TIA_LINE_CLOCKS + 2880;  // 12000
  localparam logic [3:0] CS_ON  = {2'b00, `TIA_CS_SELECT};

  logic        CCLK, rst_n;
  logic        r_w;
  logic [3:0]  cs;
  logic [5:0]  a, i;
  logic [7:0]  d_in, d_out;
  logic        rdy, hsync, hblank, vsync, vblank;
  logic [2:0]  lum;
  logic [3:0]  col;
  logic [7:0]  m_count;  // model line position
  logic        m_halt;   // WSYNC pending
  logic [1:0]  m_latch;  // INPT4/5 latches
  logic [7:0]  m_dout;
  logic [7:0]  sh_vsync, sh_vblank, sh_ctrl, sh_pf0, sh_pf1, sh_pf2;  // register copies
  logic [7:0]  sh_c0, sh_c1, sh_cpf, sh_cbk;
  logic [7:0]  exp_colour;
  logic        bus_wr, bus_rd, read_bit;
  logic [31:0] lfsr_state;
  int          errors, errors_before, tests, failed_tests, cycles;

  `include "tb_tia_checks.svh"

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clock (.*);
  tia_top DUT (.*);

  assign bus_wr = (cs[1:0] == `TIA_CS_SELECT) && !r_w;
  assign bus_rd = (cs[1:0] == `TIA_CS_SELECT) && r_w;
  assign exp_colour = expect_colour(m_count, sh_pf0, sh_pf1, sh_pf2, sh_ctrl,
                                    sh_c0, sh_c1, sh_cpf, sh_cbk);

  // input port read value, bit 7 of d_out
  always_comb begin
    case (a)
      tia_pkg::INPT0, tia_pkg::INPT1, tia_pkg::INPT2, tia_pkg::INPT3:
        read_bit = sh_vblank[7] ? 1'b0 : i[a - 6'h08];  // dumped
      tia_pkg::INPT4, tia_pkg::INPT5:
        read_bit = sh_vblank[6] ? m_latch[a - 6'h0C] : i[a - 6'h08];
      default: read_bit = 1'b0;
    endcase
  end

  // model, steps with the DUT on each edge
  always @(posedge CCLK) begin
    if (!rst_n) begin
      m_count <= '0;
      m_halt  <= 1'b0;
      m_latch <= 2'b00;
      m_dout  <= '0;
      {sh_vsync, sh_vblank, sh_ctrl, sh_pf0, sh_pf1, sh_pf2} <= '0;
      {sh_c0, sh_c1, sh_cpf, sh_cbk} <= '0;
    end else begin
      if (bus_wr && a == tia_pkg::RSYNC) m_count <= '0;
      else if (m_count == `TIA_LINE_CLOCKS - 1) m_count <= '0;
      else m_count <= m_count + 8'd1;
      if (bus_wr && a == tia_pkg::WSYNC) m_halt <= 1'b1;
      else if (m_count == 8'd0) m_halt <= 1'b0;  // released after count 0
      if (bus_wr && a == tia_pkg::VBLANK && d_in[6]) m_latch <= 2'b11;
      else if (sh_vblank[6]) m_latch <= m_latch & i[5:4];  // low input sticks
      if (bus_rd) m_dout <= {read_bit, 7'd0};
      if (bus_wr) begin
        case (a)
          tia_pkg::VSYNC:  sh_vsync  <= d_in;
          tia_pkg::VBLANK: sh_vblank <= d_in;
          tia_pkg::COLUP0: sh_c0     <= d_in;
          tia_pkg::COLUP1: sh_c1     <= d_in;
          tia_pkg::COLUPF: sh_cpf    <= d_in;
          tia_pkg::COLUBK: sh_cbk    <= d_in;
          tia_pkg::CTRLPF: sh_ctrl   <= d_in;
          tia_pkg::PF0:    sh_pf0    <= d_in;
          tia_pkg::PF1:    sh_pf1    <= d_in;
          tia_pkg::PF2:    sh_pf2    <= d_in;
          default: ;
        endcase
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got, exp);
    errors++;
    $display("ERROR t=%0t %s dut=%0h expected=%0h", $time, name, got, exp);
  endtask

  task automatic begin_test();
    errors_before = errors;
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
    end
  endtask

  // sampled before each edge, so bus drive order does not matter
  a_hblank: assert property (@(posedge CCLK) disable iff (!rst_n)
      hblank == (m_count < `TIA_HBLANK_END))
    else report_mismatch("hblank", $sampled(hblank), $sampled(m_count < `TIA_HBLANK_END));
  a_hsync: assert property (@(posedge CCLK) disable iff (!rst_n)
      hsync == (m_count >= `TIA_HSYNC_START && m_count < `TIA_HSYNC_END))
    else report_mismatch("hsync", $sampled(hsync),
                         $sampled(m_count >= `TIA_HSYNC_START && m_count < `TIA_HSYNC_END));
  a_rdy: assert property (@(posedge CCLK) disable iff (!rst_n) rdy == !m_halt)
    else report_mismatch("rdy", $sampled(rdy), $sampled(!m_halt));
  a_lum: assert property (@(posedge CCLK) disable iff (!rst_n) lum == exp_colour[3:1])
    else report_mismatch("lum", $sampled(lum), $sampled(exp_colour[3:1]));
  a_col: assert property (@(posedge CCLK) disable iff (!rst_n) col == exp_colour[7:4])
    else report_mismatch("col", $sampled(col), $sampled(exp_colour[7:4]));
  a_vsync: assert property (@(posedge CCLK) disable iff (!rst_n) vsync == sh_vsync[1])
    else report_mismatch("vsync", $sampled(vsync), $sampled(sh_vsync[1]));
  a_vblank: assert property (@(posedge CCLK) disable iff (!rst_n) vblank == sh_vblank[1])
    else report_mismatch("vblank", $sampled(vblank), $sampled(sh_vblank[1]));
  a_dout: assert property (@(posedge CCLK) disable iff (!rst_n) d_out == m_dout)
    else report_mismatch("d_out", $sampled(d_out), $sampled(m_dout));

  always @(posedge CCLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    logic [7:0] v;
    r_w  <= 1'b1;
    cs   <= 4'b0000;
    a    <= '0;
    d_in <= '0;
    i    <= 6'h3f;
    lfsr_state = 32'hd39f_b782;
    {errors, errors_before, tests, failed_tests, cycles} = '0;
    wait (rst_n);
    @(posedge CCLK);
    begin_test();
    repeat (3) wait_line_start();
    report_test("line timing");
    begin_test();
    wait_visible();
    write_reg(tia_pkg::RSYNC, 8'h00);  // restart mid-line
    wait_line_start();
    wait_hsync();
    write_reg(tia_pkg::RSYNC, 8'h00);  // and inside hsync
    repeat (2) wait_line_start();
    report_test("rsync");
    begin_test();
    wait_visible();
    write_reg(tia_pkg::WSYNC, 8'h00);
    wait_ready();
    wait_hsync();
    write_reg(tia_pkg::WSYNC, 8'h00);
    wait_ready();
    write_reg(tia_pkg::WSYNC, 8'h00);  // right after a release
    wait_ready();
    report_test("wsync");
    begin_test();
    for (int mode = 0; mode < 4; mode++) begin  // reflect and score, all four
      write_random(tia_pkg::PF0);
      write_random(tia_pkg::PF1);
      write_random(tia_pkg::PF2);
      write_random(tia_pkg::COLUP0);
      write_random(tia_pkg::COLUP1);
      write_random(tia_pkg::COLUPF);
      write_random(tia_pkg::COLUBK);
      rand_byte(v);
      write_reg(tia_pkg::CTRLPF, {v[7:2], 2'(mode)});
      repeat (2) wait_line_start();
    end
    report_test("playfield video");
    begin_test();
    write_reg(tia_pkg::VSYNC, 8'h02);
    write_reg(tia_pkg::VBLANK, 8'h02);
    write_reg(tia_pkg::VSYNC, 8'hfd);
    write_reg(tia_pkg::VBLANK, 8'h3d);
    repeat (4) begin
      write_random(tia_pkg::VSYNC);
      write_random(tia_pkg::VBLANK);
    end
    report_test("sync levels");
    begin_test();
    write_reg(tia_pkg::VBLANK, 8'h00);
    repeat (4) begin
      rand_byte(v);
      i <= v[5:0];
      for (int k = 0; k < 6; k++) read_reg(6'(tia_pkg::INPT0 + k));
    end
    i <= 6'h3f;  // all high, so dump shows
    write_reg(tia_pkg::VBLANK, 8'h80);  // dump INPT0..3
    for (int k = 0; k < 4; k++) read_reg(6'(tia_pkg::INPT0 + k));
    write_reg(tia_pkg::VBLANK, 8'h40);  // latch mode, both latches set
    read_reg(tia_pkg::INPT4);
    read_reg(tia_pkg::INPT5);
    i <= 6'h2f;  // INPT4 pulled low
    read_reg(tia_pkg::INPT4);
    i <= 6'h3f;
    read_reg(tia_pkg::INPT4);  // stays low
    read_reg(tia_pkg::INPT5);
    i <= 6'h1f;
    read_reg(tia_pkg::INPT5);
    i <= 6'h3f;
    read_reg(tia_pkg::INPT5);
    bus_cycle(4'b0010, 1'b1, tia_pkg::INPT0, 8'h00);  // not selected, d_out holds
    read_reg(tia_pkg::INPT0);  // d_out bit 7 high
    read_reg(6'h20);  // unmapped
    write_reg(tia_pkg::VBLANK, 8'h00);
    read_reg(tia_pkg::INPT4);
    repeat (2) @(posedge CCLK);  // last read reaches d_out
    report_test("input ports");
    $display("summary: %0d tests, %0d failed, %0d mismatches, %0d cycles",
             tests, failed_tests, errors, cycles);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
+incdir+test
hw/tia_pkg.sv
hw/tia_regs_if.sv
hw/tia_reg_decode.sv
hw/tia_beam_timer.sv
hw/tia_playfield_video.sv
hw/tia_input_ports.sv
hw/tia_top.sv
test/tb_clock.sv
test/tb_tia.sv

//--- Bender.yml
package:
  name: tia_lite

export_include_dirs:
  - hw

sources:
  - files:
      - hw/tia_pkg.sv
      - hw/tia_regs_if.sv
      - hw/tia_reg_decode.sv
      - hw/tia_beam_timer.sv
      - hw/tia_playfield_video.sv
      - hw/tia_input_ports.sv
      - hw/tia_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_clock.sv
      - test/tb_tia.sv
